//--- src/loop_config.svh
`ifndef LOOP_CONFIG_SVH
`define LOOP_CONFIG_SVH

// data widths of the converter side
`define LOOP_ADC_W 14
`define LOOP_RAMP_W 16

// register word addresses on the control bus
`define LOOP_REG_CTRL 3'd0 // bit 0 enable, bits 7:4 gain select
`define LOOP_REG_LIMIT 3'd1
`define LOOP_REG_HALF 3'd2
`define LOOP_REG_STEP 3'd3 // read only
`define LOOP_REG_RAMP 3'd4 // read only

// register values out of reset
`define LOOP_RST_GAIN 4'd5
`define LOOP_RST_LIMIT 32'd5000
`define LOOP_RST_HALF 16'd8

// square-wave modulation depth, a quarter of the full 2pi wrap
`define LOOP_MOD_BIAS 16'd16384

`endif

//--- src/loop_types_pkg.sv
`include "loop_config.svh"

package loop_types_pkg;

	typedef logic signed [`LOOP_ADC_W-1:0] adc_t; // one converter sample
	typedef logic signed [31:0] err_t; // demodulated error of one period
	typedef logic signed [31:0] step_t; // integrator and clamped step
	typedef logic [31:0] lim_t; // magnitude of the step limit
	typedef logic [3:0] gain_t; // right shift amount, 15 opens the loop
	typedef logic [15:0] half_len_t; // half period length in clocks
	typedef logic [`LOOP_RAMP_W-1:0] ramp_t; // phase ramp, full wrap is 2pi

	// one modulation period runs FIRST, SECOND, INTEG, CLAMP, RAMP
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FIRST,
		ST_SECOND,
		ST_INTEG,
		ST_CLAMP,
		ST_RAMP
	} seq_state_t;

endpackage

//--- src/wb_bus_pkg.sv
package wb_bus_pkg;

	typedef logic [2:0] wb_adr_t; // register word address

	// master to slave signals of a classic cycle
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_adr_t adr;
		logic [31:0] dat_w;
	} wb_req_t;

	// slave to master signals
	typedef struct packed {
		logic ack;
		logic [31:0] dat_r;
	} wb_rsp_t;

endpackage

//--- src/loop_regs.sv
`timescale 1ns/1ps
`include "loop_config.svh"

module loop_regs
	import loop_types_pkg::*, wb_bus_pkg::*;
(
	input logic i_clk,
	input logic i_rst_n,
	input wb_req_t i_wb,
	output wb_rsp_t o_wb,
	input step_t i_step,
	input ramp_t i_ramp,
	output logic o_enable,
	output gain_t o_gain,
	output lim_t o_limit,
	output half_len_t o_half_len
);

	logic ack;
	logic [31:0] dat_r;
	logic req_new; // request seen while no ack is pending
	logic [31:0] rd_mux;

	assign req_new = i_wb.cyc && i_wb.stb && !ack;

	// readback selection, the step is sign extended and the ramp zero extended
	always_comb begin
		case (i_wb.adr)
			`LOOP_REG_CTRL: rd_mux = {24'd0, o_gain, 3'd0, o_enable};
			`LOOP_REG_LIMIT: rd_mux = o_limit;
			`LOOP_REG_HALF: rd_mux = {16'd0, o_half_len};
			`LOOP_REG_STEP: rd_mux = 32'(i_step);
			`LOOP_REG_RAMP: rd_mux = {{(32-`LOOP_RAMP_W){1'b0}}, i_ramp};
			default: rd_mux = 32'd0; // unmapped words read as zero
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= req_new; // a held strobe gets an ack every second cycle
		end
	end

	// writable settings, stored on the edge that raises ack
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_enable <= 1'b0;
			o_gain <= `LOOP_RST_GAIN;
			o_limit <= `LOOP_RST_LIMIT;
			o_half_len <= `LOOP_RST_HALF;
		end else if (req_new && i_wb.we) begin
			case (i_wb.adr)
				`LOOP_REG_CTRL: begin
					o_enable <= i_wb.dat_w[0];
					o_gain <= i_wb.dat_w[7:4];
				end
				`LOOP_REG_LIMIT: o_limit <= i_wb.dat_w;
				`LOOP_REG_HALF: o_half_len <= i_wb.dat_w[15:0];
				default: ; // read only and unmapped words ignore writes
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (req_new) begin
			dat_r <= rd_mux; // valid during the ack cycle
		end
	end

	assign o_wb.ack = ack;
	assign o_wb.dat_r = dat_r;

endmodule

//--- src/loop_sequencer.sv
`timescale 1ns/1ps

module loop_sequencer
	import loop_types_pkg::*;
(
	input logic i_clk,
	input logic i_rst_n,
	input logic i_enable,
	input logic i_tick,
	output logic o_load,
	output logic o_clr,
	output logic o_sample,
	output logic o_second,
	output logic o_trig,
	output logic o_clamp,
	output logic o_advance
);

	seq_state_t state;
	seq_state_t state_nxt;
	logic enter_first; // the next edge starts a new period

	assign enter_first = i_enable && (state == ST_IDLE || state == ST_RAMP);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: if (i_enable) state_nxt = ST_FIRST;
			ST_FIRST: if (i_tick) state_nxt = ST_SECOND;
			ST_SECOND: if (i_tick) state_nxt = ST_INTEG;
			ST_INTEG: state_nxt = ST_CLAMP;
			ST_CLAMP: state_nxt = ST_RAMP;
			ST_RAMP: state_nxt = i_enable ? ST_FIRST : ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// the timer is reloaded on the edge that opens each half
	assign o_load = enter_first || (state == ST_FIRST && i_tick);
	assign o_clr = enter_first; // demod sum starts from zero in ST_FIRST
	assign o_sample = (state == ST_FIRST) || (state == ST_SECOND);
	assign o_second = (state == ST_SECOND);
	assign o_trig = (state == ST_INTEG);
	assign o_clamp = (state == ST_CLAMP);
	assign o_advance = (state == ST_RAMP); // doubles as the period sync

endmodule

//--- src/half_period_timer.sv
`timescale 1ns/1ps

module half_period_timer
	import loop_types_pkg::*;
(
	input logic i_clk,
	input logic i_rst_n,
	input logic i_load,
	input half_len_t i_half_len,
	output logic o_tick
);

	half_len_t count;
	half_len_t load_val;

	// a zero length behaves like a one clock half
	assign load_val = (i_half_len == '0) ? '0 : i_half_len - 16'd1;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			count <= '0;
		end else if (i_load) begin
			count <= load_val;
		end else if (count != '0) begin
			count <= count - 16'd1; // parks at zero until the next load
		end
	end

	assign o_tick = (count == '0); // last cycle of the half

endmodule

//--- src/err_demod.sv
`timescale 1ns/1ps

module err_demod
	import loop_types_pkg::*;
(
	input logic i_clk,
	input logic i_rst_n,
	input logic i_clr,
	input logic i_sample,
	input logic i_second,
	input adc_t i_adc,
	output err_t o_err
);

	err_t acc;
	err_t sample_ext;

	assign sample_ext = err_t'(i_adc); // signed cast extends the sign bit

	// first half subtracts and second half adds, so a rate offset
	// between the two modulation states shows up as a nonzero sum
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			acc <= '0;
		end else if (i_clr) begin
			acc <= '0;
		end else if (i_sample) begin
			if (i_second) begin
				acc <= acc + sample_ext;
			end else begin
				acc <= acc - sample_ext;
			end
		end
	end

	assign o_err = acc; // held outside the two halves for the integrator

endmodule

//--- src/feedback_step_gen.sv
`timescale 1ns/1ps
`include "loop_config.svh"

module feedback_step_gen
	import loop_types_pkg::*;
(
	input logic i_clk,
	input logic i_rst_n,
	input logic i_trig,
	input logic i_clamp,
	input err_t i_err,
	input gain_t i_gain_sel,
	input lim_t i_step_max,
	output logic o_fb_on,
	output step_t o_step
);

	gain_t shift_q;
	step_t step_max;
	step_t step_min;
	step_t integ;
	logic fb_on;

	assign fb_on = (shift_q != 4'd15); // gain 15 opens the loop

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			shift_q <= `LOOP_RST_GAIN;
			step_max <= step_t'(`LOOP_RST_LIMIT);
			step_min <= -step_t'(`LOOP_RST_LIMIT);
		end else begin
			shift_q <= i_gain_sel;
			step_max <= step_t'(i_step_max);
			step_min <= -step_t'(i_step_max); // symmetric lower bound
		end
	end

	// the integrator keeps running while the output sits at a limit
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			integ <= '0;
			o_step <= '0;
		end else if (!fb_on) begin
			integ <= '0;
			o_step <= '0;
		end else begin
			if (i_trig) integ <= integ + (i_err >>> shift_q);
			if (i_clamp) begin
				if (integ > step_max) o_step <= step_max;
				else if (integ < step_min) o_step <= step_min;
				else o_step <= integ;
			end
		end
	end

	assign o_fb_on = fb_on;

endmodule

//--- src/phase_ramp.sv
`timescale 1ns/1ps
`include "loop_config.svh"

module phase_ramp
	import loop_types_pkg::*;
(
	input logic i_clk,
	input logic i_rst_n,
	input logic i_advance,
	input logic i_first_half,
	input step_t i_step,
	output ramp_t o_ramp,
	output ramp_t o_dac
);

	ramp_t ramp;
	ramp_t dac;

	// the ramp wraps naturally at 2pi, only the low bits of the step count
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ramp <= '0;
		end else if (i_advance) begin
			ramp <= ramp + i_step[`LOOP_RAMP_W-1:0];
		end
	end

	// square wave bias of a quarter wrap rides on top of the ramp
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			dac <= `LOOP_MOD_BIAS;
		end else if (i_first_half) begin
			dac <= ramp + `LOOP_MOD_BIAS;
		end else begin
			dac <= ramp - `LOOP_MOD_BIAS;
		end
	end

	assign o_ramp = ramp;
	assign o_dac = dac;

endmodule

//--- src/loop_top.sv
`timescale 1ns/1ps

module loop_top
	import loop_types_pkg::*, wb_bus_pkg::*;
(
	input logic i_clk,
	input logic i_rst_n,
	input wb_req_t i_wb,
	output wb_rsp_t o_wb,
	input adc_t i_adc,
	output ramp_t o_dac,
	output logic o_sync,
	output logic o_fb_on
);

	logic enable;
	gain_t gain;
	lim_t limit;
	half_len_t half_len;
	logic load;
	logic clr;
	logic sample;
	logic second;
	logic trig;
	logic clamp;
	logic advance;
	logic tick;
	err_t err;
	step_t step;
	ramp_t ramp;

	loop_regs u_regs (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_wb(i_wb),
		.o_wb(o_wb),
		.i_step(step),
		.i_ramp(ramp),
		.o_enable(enable),
		.o_gain(gain),
		.o_limit(limit),
		.o_half_len(half_len)
	);

	loop_sequencer u_seq (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_enable(enable),
		.i_tick(tick),
		.o_load(load),
		.o_clr(clr),
		.o_sample(sample),
		.o_second(second),
		.o_trig(trig),
		.o_clamp(clamp),
		.o_advance(advance)
	);

	half_period_timer u_timer (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_load(load),
		.i_half_len(half_len),
		.o_tick(tick)
	);

	err_demod u_demod (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_clr(clr),
		.i_sample(sample),
		.i_second(second),
		.i_adc(i_adc),
		.o_err(err)
	);

	feedback_step_gen u_step (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_trig(trig),
		.i_clamp(clamp),
		.i_err(err),
		.i_gain_sel(gain),
		.i_step_max(limit),
		.o_fb_on(o_fb_on),
		.o_step(step)
	);

	phase_ramp u_ramp (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_advance(advance),
		.i_first_half(~second), // idle and the strobe states count as first half
		.i_step(step),
		.o_ramp(ramp),
		.o_dac(o_dac)
	);

	assign o_sync = advance;

endmodule

//--- testbench/tb_loop_top.sv
`timescale 1ns/1ps
`include "loop_config.svh"

module tb_loop_top
	import loop_types_pkg::*, wb_bus_pkg::*;
();

	logic i_clk = 1'b0;
	logic i_rst_n;
	wb_req_t i_wb;
	wb_rsp_t o_wb;
	adc_t i_adc;
	ramp_t o_dac;
	logic o_sync;
	logic o_fb_on;

	int errors = 0;
	int checks = 0;
	int running = 0;
	int c_gain, c_lim, c_hl; // configuration the DUT runs with
	int m_integ = 0; // reference model of the step generator and ramp
	int m_clamp = 0;
	logic [15:0] m_ramp = 16'd0;
	string m_name;

	loop_top u_dut (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_wb(i_wb), .o_wb(o_wb),
		.i_adc(i_adc), .o_dac(o_dac), .o_sync(o_sync), .o_fb_on(o_fb_on));

	always #4 i_clk = ~i_clk;

	task automatic abort_run(input string msg);
		errors++;
		$display("error: %s", msg);
		$display("checks %0d errors %0d", checks, errors);
		$display("Test failures found");
		$finish;
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s expected %0d actual %0d", name, $signed(exp), $signed(act));
		end
	endtask

	// one classic cycle, stb drops on the falling edge that sees ack
	task automatic bus_transfer(input logic we, input wb_adr_t adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		int n;
		n = 0;
		@(negedge i_clk);
		i_wb.cyc = 1'b1;
		i_wb.stb = 1'b1;
		i_wb.we = we;
		i_wb.adr = adr;
		i_wb.dat_w = wdat;
		@(negedge i_clk);
		while (!o_wb.ack && n < 20) begin
			n++;
			@(negedge i_clk);
		end
		if (!o_wb.ack) begin
			abort_run("bus transfer got no ack");
		end else begin
			rdat = o_wb.dat_r;
			i_wb = '0;
			@(negedge i_clk);
			check("single ack", 32'd0, 32'(o_wb.ack)); // ack must not repeat
		end
	endtask

	task automatic wb_write(input wb_adr_t adr, input logic [31:0] data);
		logic [31:0] ignored;
		bus_transfer(1'b1, adr, data, ignored);
	endtask

	task automatic wb_read(input wb_adr_t adr, output logic [31:0] data);
		bus_transfer(1'b0, adr, 32'd0, data);
	endtask

	task automatic wait_sync();
		int n;
		n = 0;
		@(negedge i_clk);
		while (!o_sync && n <= 4 * c_hl + 20) begin
			n++;
			@(negedge i_clk);
		end
		if (!o_sync) abort_run("no o_sync within one period");
	endtask

	// the ramp holds through the period, so the DAC word is ramp plus or minus the bias
	task automatic drive_levels(input int a, input int b);
		ramp_t dac_exp;
		for (int i = 0; i < 2 * c_hl; i++) begin
			@(negedge i_clk);
			i_adc = (i < c_hl) ? adc_t'(a) : adc_t'(b); // a in the first half
			if (i == 1) begin
				dac_exp = m_ramp + `LOOP_MOD_BIAS;
				check("dac first half", 32'(dac_exp), 32'(o_dac));
			end
			if (i == c_hl + 1) begin
				dac_exp = m_ramp - `LOOP_MOD_BIAS;
				check("dac second half", 32'(dac_exp), 32'(o_dac));
			end
		end
	endtask

	// expected step and ramp at the end of one period with constant levels
	task automatic model_period(input string name, input int a, input int b);
		int err;
		err = c_hl * (b - a);
		if (c_gain == 15) begin
			m_integ = 0;
			m_clamp = 0;
		end else begin
			m_integ = m_integ + (err >>> c_gain);
			if (m_integ > c_lim) m_clamp = c_lim;
			else if (m_integ < -c_lim) m_clamp = -c_lim;
			else m_clamp = m_integ;
		end
		m_ramp = m_ramp + m_clamp[15:0];
		m_name = name;
	endtask

	task automatic check_period();
		logic [31:0] d;
		check({m_name, " fb_on"}, 32'(c_gain != 15), 32'(o_fb_on));
		wb_read(`LOOP_REG_STEP, d);
		check({m_name, " step"}, m_clamp, d);
		wb_read(`LOOP_REG_RAMP, d);
		check({m_name, " ramp"}, 32'(m_ramp), d);
	endtask

	// the first period after enable samples a zero input
	task automatic start_loop(input int gain, input int lim, input int hl);
		wb_write(`LOOP_REG_LIMIT, lim);
		wb_write(`LOOP_REG_HALF, hl);
		wb_write(`LOOP_REG_CTRL, (gain << 4) | 1);
		c_gain = gain;
		c_lim = lim;
		c_hl = hl;
		model_period("lead_in", 0, 0);
		wait_sync();
		running = 1;
	endtask

	task automatic stop_loop();
		logic [31:0] d;
		int quiet;
		fork
			begin
				check_period();
				wb_write(`LOOP_REG_CTRL, c_gain << 4);
			end
			drive_levels(0, 0);
		join
		model_period("trailer", 0, 0); // the period already started runs to its end
		wait_sync();
		check_period();
		quiet = 1;
		repeat (2 * (2 * c_hl + 3)) begin
			@(negedge i_clk);
			if (o_sync) quiet = 0;
		end
		if (!quiet) begin
			errors++;
			$display("error: o_sync kept pulsing after enable was cleared");
		end
		wb_read(`LOOP_REG_RAMP, d);
		check("stopped ramp", 32'(m_ramp), d);
		running = 0;
	endtask

	task automatic run_patterns();
		int fd;
		string line;
		string tname;
		int en, gain, lim, hl, a, b;
		fd = $fopen("testbench/loop_patterns.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("error: cannot open testbench/loop_patterns.txt");
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line[0] == "#") continue;
				if ($sscanf(line, "%s %d %d %d %d %d %d", tname, en, gain, lim, hl, a, b) != 7)
					continue;
				if (a == 9999 && b == 9999) begin
					a = int'($urandom % 1001) - 500;
					b = int'($urandom % 1001) - 500;
					$display("%s uses random levels a=%0d b=%0d", tname, a, b);
				end
				if (running != 0 && (en == 0 || hl != c_hl)) stop_loop();
				if (en != 0) begin
					if (running == 0) start_loop(gain, lim, hl);
					fork
						begin
							check_period(); // the period that ended at this sync
							wb_write(`LOOP_REG_LIMIT, lim);
							wb_write(`LOOP_REG_CTRL, (gain << 4) | 1);
						end
						drive_levels(a, b);
					join
					c_gain = gain;
					c_lim = lim;
					model_period(tname, a, b);
					wait_sync();
				end
			end
			$fclose(fd);
			if (running != 0) stop_loop();
		end
	endtask

	initial begin
		logic [31:0] d;
		int quiet;
		void'($urandom(90660));
		i_rst_n = 1'b0;
		i_wb = '0;
		i_adc = '0;
		repeat (10) @(negedge i_clk);
		i_rst_n = 1'b1;
		wb_read(`LOOP_REG_CTRL, d);
		check("reset ctrl", 32'h50, d); // gain 5, enable 0
		wb_read(`LOOP_REG_LIMIT, d);
		check("reset limit", 32'd5000, d);
		wb_read(`LOOP_REG_HALF, d);
		check("reset half", 32'd8, d);
		wb_read(`LOOP_REG_STEP, d);
		check("reset step", 32'd0, d);
		wb_read(`LOOP_REG_RAMP, d);
		check("reset ramp", 32'd0, d);
		check("reset dac", 32'(`LOOP_MOD_BIAS), 32'(o_dac));
		quiet = 1;
		repeat (50) begin
			@(negedge i_clk);
			if (o_sync) quiet = 0;
		end
		if (!quiet) begin
			errors++;
			$display("error: o_sync pulsed while the loop was disabled");
		end
		wb_write(`LOOP_REG_LIMIT, 32'd1234);
		wb_read(`LOOP_REG_LIMIT, d);
		check("limit readback", 32'd1234, d);
		wb_write(`LOOP_REG_HALF, 32'd10);
		wb_read(`LOOP_REG_HALF, d);
		check("half readback", 32'd10, d);
		wb_write(`LOOP_REG_CTRL, 32'hffff_ff30); // unused control bits are dropped
		wb_read(`LOOP_REG_CTRL, d);
		check("ctrl readback", 32'h30, d);
		wb_write(`LOOP_REG_STEP, 32'h1234);
		wb_read(`LOOP_REG_STEP, d);
		check("step write ignored", 32'd0, d);
		wb_read(3'd6, d);
		check("unmapped read", 32'd0, d);
		run_patterns();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- testbench/loop_patterns.txt
# name enable gain limit half_len level_a level_b, one modulation period per line
# level_a is driven in the first half and level_b in the second, 9999 9999 draws random levels
integ_1 1 0 30000 12 -100 400
integ_2 1 0 30000 12 -100 400
integ_3 1 0 30000 12 -100 400
integ_4 1 0 30000 12 -100 400
integ_5 1 0 30000 12 -100 400
rand_1 1 3 30000 12 9999 9999
rand_2 1 3 30000 12 9999 9999
off_1 1 15 30000 12 -100 400
off_2 1 15 30000 12 -100 400
restart_1 1 5 30000 12 -100 400
stop_1 0 5 30000 12 0 0
clamp_up_1 1 2 300 16 0 200
clamp_up_2 1 2 300 16 0 200
clamp_dn_1 1 2 300 16 200 0
clamp_dn_2 1 2 300 16 200 0
clamp_dn_3 1 2 300 16 200 0
clamp_dn_4 1 2 300 16 200 0
stop_2 0 2 300 16 0 0

//--- all.f
+incdir+src
src/loop_types_pkg.sv
src/wb_bus_pkg.sv
src/loop_regs.sv
src/loop_sequencer.sv
src/half_period_timer.sv
src/err_demod.sv
src/feedback_step_gen.sv
src/phase_ramp.sv
src/loop_top.sv
testbench/tb_loop_top.sv

//--- run.sh
#!/bin/sh
# builds the loop testbench with Verilator, runs it and checks the log
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_loop_top \
	-o sim_loop && ./obj_dir/sim_loop | tee sim.log
grep -q "All tests passed!" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
